/* uart_pkg.sv */
//====================================================================
// UART subsystem shared definitions
// Register map, bit masks, start-up configuration values and bus widths.
//====================================================================

package uart_pkg;

	// Wishbone bus widths.
	localparam int WB_ADDR_W = 3;
	localparam int WB_DATA_W = 8;
	localparam int DIV_W     = 16;

	// 16550 register addresses; 0 and 1 switch to the divisor with DLAB.
	localparam logic [WB_ADDR_W-1:0] REG_THR_DLL = 3'd0;
	localparam logic [WB_ADDR_W-1:0] REG_IER_DLM = 3'd1;
	localparam logic [WB_ADDR_W-1:0] REG_FCR     = 3'd2;
	localparam logic [WB_ADDR_W-1:0] REG_LCR     = 3'd3;
	localparam logic [WB_ADDR_W-1:0] REG_LSR     = 3'd5;

	localparam logic [WB_DATA_W-1:0] LCR_DLAB  = 8'h80; // Divisor latch access.
	localparam logic [WB_DATA_W-1:0] LSR_THRE  = 8'h20; // Holding register empty.
	localparam logic [WB_DATA_W-1:0] IER_ETBEI = 8'h02; // Tx empty interrupt enable.

	// Start-up configuration.
	localparam logic [DIV_W-1:0]     CFG_DIVISOR = 16'd8;
	localparam logic [WB_DATA_W-1:0] CFG_LCR     = 8'h03; // 8N1.
	localparam logic [WB_DATA_W-1:0] CFG_FCR     = 8'h00;

	// Index of the last bus access in the configuration sequence.
	localparam logic [3:0] CFG_LAST_STEP = 4'd8;

	// Frame bit index of the stop bit, start bit is index 0.
	localparam logic [3:0] TX_STOP_BIT = 4'd9;

endpackage

/* uart_tx_core.sv */
//====================================================================
// UART transmit serializer
// Start bit, eight data bits LSB first and one stop bit per frame,
// each bit lasting divisor clock cycles.
//====================================================================

`timescale 1ns/1ps

module uart_tx_core (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            start_i,
	input  logic [uart_pkg::WB_DATA_W-1:0] byte_i,
	input  logic [uart_pkg::DIV_W-1:0]     divisor_i,
	output logic                            txd_o,
	output logic                            busy_o
);
	import uart_pkg::*;

	logic [DIV_W-1:0]     cnt_q;
	logic [3:0]           idx_q; // Bit within the frame.
	logic [WB_DATA_W-1:0] shift_q;
	logic                 busy_q, txd_q;
	logic                 bit_end, data_next;

	assign bit_end   = (cnt_q == divisor_i - 16'd1);
	assign data_next = (idx_q < TX_STOP_BIT - 4'd1); // Next bit is a data bit.

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			busy_q <= 1'b0;
			txd_q  <= 1'b1;
			cnt_q  <= '0;
			idx_q  <= '0;
		end else if (!busy_q) begin
			if (start_i) begin
				busy_q <= 1'b1;
				txd_q  <= 1'b0; // Start bit.
				cnt_q  <= '0;
				idx_q  <= '0;
			end
		end else if (bit_end) begin
			cnt_q <= '0;
			if (idx_q == TX_STOP_BIT) begin
				busy_q <= 1'b0;
			end else begin
				idx_q <= idx_q + 4'd1;
				txd_q <= data_next ? shift_q[0] : 1'b1;
			end
		end else begin
			cnt_q <= cnt_q + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy_q && start_i)
			shift_q <= byte_i;
		else if (busy_q && bit_end && data_next)
			shift_q <= shift_q >> 1;
	end

	assign txd_o  = txd_q;
	assign busy_o = busy_q;

endmodule

/* uart_regs.sv */
//====================================================================
// UART register block
// 16550 subset as a Wishbone slave, DLAB-switched divisor access,
// hands each THR byte to the serializer.
//====================================================================

`timescale 1ns/1ps

module uart_regs (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            wb_cyc_i,
	input  logic                            wb_stb_i,
	input  logic                            wb_we_i,
	input  logic [uart_pkg::WB_ADDR_W-1:0] wb_adr_i,
	input  logic [uart_pkg::WB_DATA_W-1:0] wb_dat_i,
	output logic [uart_pkg::WB_DATA_W-1:0] wb_dat_o,
	output logic                            wb_ack_o,
	output logic                            tx_start_o,
	output logic [uart_pkg::WB_DATA_W-1:0] tx_byte_o,
	output logic [uart_pkg::DIV_W-1:0]     divisor_o,
	input  logic                            tx_busy_i,
	output logic                            irq_o
);
	import uart_pkg::*;

	logic [WB_DATA_W-1:0] lcr_q, ier_q, fcr_q, dll_q, dlm_q, thr_q;
	logic [WB_DATA_W-1:0] rdata, rdata_q;
	logic                 ack_q, start_q, thr_pending_q;
	logic                 access, dlab, thre;

	assign access = wb_cyc_i & wb_stb_i & ~ack_q; // One access per ack.
	assign dlab   = |(lcr_q & LCR_DLAB);
	assign thre   = ~thr_pending_q & ~start_q & ~tx_busy_i;
	assign irq_o  = |(ier_q & IER_ETBEI) & thre;

	always_comb begin
		case (wb_adr_i)
			REG_THR_DLL: rdata = dlab ? dll_q : '0; // No receiver.
			REG_IER_DLM: rdata = dlab ? dlm_q : ier_q;
			REG_FCR:     rdata = fcr_q;
			REG_LCR:     rdata = lcr_q;
			REG_LSR:     rdata = thre ? LSR_THRE : '0;
			default:     rdata = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			lcr_q         <= '0;
			ier_q         <= '0;
			fcr_q         <= '0;
			dll_q         <= '0;
			dlm_q         <= '0;
			ack_q         <= 1'b0;
			start_q       <= 1'b0;
			thr_pending_q <= 1'b0;
		end else begin
			ack_q   <= access;
			start_q <= 1'b0;
			if (thr_pending_q && !tx_busy_i) begin
				start_q       <= 1'b1;
				thr_pending_q <= 1'b0;
			end
			if (access && wb_we_i) begin
				case (wb_adr_i)
					REG_THR_DLL: begin
						if (dlab) dll_q <= wb_dat_i;
						else thr_pending_q <= 1'b1;
					end
					REG_IER_DLM: begin
						if (dlab) dlm_q <= wb_dat_i;
						else ier_q <= wb_dat_i;
					end
					REG_FCR: fcr_q <= wb_dat_i;
					REG_LCR: lcr_q <= wb_dat_i;
					default: ; // LSR is read-only.
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access && !wb_we_i)
			rdata_q <= rdata;
		if (access && wb_we_i && wb_adr_i == REG_THR_DLL && !dlab)
			thr_q <= wb_dat_i;
	end

	assign wb_ack_o   = ack_q;
	assign wb_dat_o   = rdata_q;
	assign tx_start_o = start_q;
	assign tx_byte_o  = thr_q;
	assign divisor_o  = {dlm_q, dll_q};

endmodule

/* wb_arbiter.sv */
//====================================================================
// Two-master Wishbone arbiter
// Fixed priority to master 0, grant held for a whole bus cycle.
//====================================================================

`timescale 1ns/1ps

module wb_arbiter (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            m0_cyc_i,
	input  logic                            m0_stb_i,
	input  logic                            m0_we_i,
	input  logic [uart_pkg::WB_ADDR_W-1:0] m0_adr_i,
	input  logic [uart_pkg::WB_DATA_W-1:0] m0_dat_i,
	output logic                            m0_ack_o,
	output logic [uart_pkg::WB_DATA_W-1:0] m0_dat_o,
	input  logic                            m1_cyc_i,
	input  logic                            m1_stb_i,
	input  logic                            m1_we_i,
	input  logic [uart_pkg::WB_ADDR_W-1:0] m1_adr_i,
	input  logic [uart_pkg::WB_DATA_W-1:0] m1_dat_i,
	output logic                            m1_ack_o,
	output logic [uart_pkg::WB_DATA_W-1:0] m1_dat_o,
	output logic                            s_cyc_o,
	output logic                            s_stb_o,
	output logic                            s_we_o,
	output logic [uart_pkg::WB_ADDR_W-1:0] s_adr_o,
	output logic [uart_pkg::WB_DATA_W-1:0] s_dat_o,
	input  logic [uart_pkg::WB_DATA_W-1:0] s_dat_i,
	input  logic                            s_ack_i
);

	logic owner_q; // 0: master 0, 1: master 1.
	logic grant;

	always_comb begin
		if (owner_q ? m1_cyc_i : m0_cyc_i)
			grant = owner_q; // Locked until the owner drops cyc.
		else if (m0_cyc_i)
			grant = 1'b0;
		else if (m1_cyc_i)
			grant = 1'b1;
		else
			grant = 1'b0;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			owner_q <= 1'b0;
		else
			owner_q <= grant;
	end

	assign s_cyc_o = grant ? m1_cyc_i : m0_cyc_i;
	assign s_stb_o = grant ? m1_stb_i : m0_stb_i;
	assign s_we_o  = grant ? m1_we_i  : m0_we_i;
	assign s_adr_o = grant ? m1_adr_i : m0_adr_i;
	assign s_dat_o = grant ? m1_dat_i : m0_dat_i;

	assign m0_ack_o = s_ack_i & ~grant;
	assign m1_ack_o = s_ack_i & grant;
	assign m0_dat_o = grant ? '0 : s_dat_i;
	assign m1_dat_o = grant ? s_dat_i : '0;

endmodule

/* uart_tx_feeder.sv */
//====================================================================
// UART transmit feeder
// Wishbone master that polls LSR and writes each input byte to THR.
//====================================================================

`timescale 1ns/1ps

module uart_tx_feeder (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            enable_i,
	input  logic                            tx_valid_i,
	input  logic [uart_pkg::WB_DATA_W-1:0] tx_data_i,
	output logic                            tx_ready_o,
	output logic                            wb_cyc_o,
	output logic                            wb_stb_o,
	output logic                            wb_we_o,
	output logic [uart_pkg::WB_ADDR_W-1:0] wb_adr_o,
	output logic [uart_pkg::WB_DATA_W-1:0] wb_dat_o,
	input  logic [uart_pkg::WB_DATA_W-1:0] wb_dat_i,
	input  logic                            wb_ack_i
);
	import uart_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_POLL, ST_GAP, ST_WRITE} state_t;

	state_t               state_q;
	logic                 thre_q;
	logic [WB_DATA_W-1:0] byte_q;

	assign tx_ready_o = enable_i & (state_q == ST_IDLE);
	assign wb_cyc_o   = (state_q == ST_POLL) || (state_q == ST_WRITE);
	assign wb_stb_o   = wb_cyc_o;
	assign wb_we_o    = (state_q == ST_WRITE);
	assign wb_adr_o   = wb_we_o ? REG_THR_DLL : REG_LSR;
	assign wb_dat_o   = byte_q;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= ST_IDLE;
			thre_q  <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: if (tx_ready_o && tx_valid_i) state_q <= ST_POLL;
				ST_POLL: begin
					if (wb_ack_i) begin
						thre_q  <= |(wb_dat_i & LSR_THRE);
						state_q <= ST_GAP;
					end
				end
				ST_GAP: state_q <= thre_q ? ST_WRITE : ST_POLL; // Keep polling while busy.
				default: if (wb_ack_i) state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (tx_ready_o && tx_valid_i)
			byte_q <= tx_data_i;
	end

endmodule

/* uart_cfg_master.sv */
//====================================================================
// UART configuration sequencer
// Wishbone master that programs divisor, line format, FIFO control
// and interrupt enable by read-modify-write after a start pulse.
//====================================================================

`timescale 1ns/1ps

module uart_cfg_master (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            start_i,
	output logic                            cfg_done_o,
	output logic                            wb_cyc_o,
	output logic                            wb_stb_o,
	output logic                            wb_we_o,
	output logic [uart_pkg::WB_ADDR_W-1:0] wb_adr_o,
	output logic [uart_pkg::WB_DATA_W-1:0] wb_dat_o,
	input  logic [uart_pkg::WB_DATA_W-1:0] wb_dat_i,
	input  logic                            wb_ack_i
);
	import uart_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_GAP, ST_DONE} state_t;

	state_t               state_q;
	logic [3:0]           step_q;
	logic [WB_DATA_W-1:0] hold_q; // Last read value.

	// Access table, one entry per step.
	always_comb begin
		wb_we_o  = 1'b1;
		wb_adr_o = REG_LCR;
		wb_dat_o = '0;
		case (step_q)
			4'd0: wb_we_o = 1'b0;
			4'd1: wb_dat_o = hold_q | LCR_DLAB;
			4'd2: begin
				wb_adr_o = REG_IER_DLM;
				wb_dat_o = CFG_DIVISOR[15:8];
			end
			4'd3: begin
				wb_adr_o = REG_THR_DLL;
				wb_dat_o = CFG_DIVISOR[7:0];
			end
			4'd4: wb_we_o = 1'b0;
			4'd5: wb_dat_o = (hold_q | CFG_LCR) & ~LCR_DLAB; // Back to THR/IER map.
			4'd6: begin
				wb_adr_o = REG_FCR;
				wb_dat_o = CFG_FCR;
			end
			4'd7: begin
				wb_we_o  = 1'b0;
				wb_adr_o = REG_IER_DLM;
			end
			default: begin
				wb_adr_o = REG_IER_DLM;
				wb_dat_o = hold_q | IER_ETBEI;
			end
		endcase
	end

	assign wb_cyc_o   = (state_q == ST_REQ);
	assign wb_stb_o   = (state_q == ST_REQ);
	assign cfg_done_o = (state_q == ST_DONE);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= ST_IDLE;
			step_q  <= '0;
		end else begin
			case (state_q)
				ST_IDLE: if (start_i) state_q <= ST_REQ;
				ST_REQ: begin
					if (wb_ack_i) begin
						state_q <= (step_q == CFG_LAST_STEP) ? ST_DONE : ST_GAP;
					end
				end
				ST_GAP: begin
					// Idle cycle between accesses.
					step_q  <= step_q + 4'd1;
					state_q <= ST_REQ;
				end
				default: state_q <= state_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == ST_REQ && wb_ack_i && !wb_we_o)
			hold_q <= wb_dat_i;
	end

endmodule

/* uart_subsys.sv */
//====================================================================
// UART transmit subsystem top level
// Two Wishbone masters share the register block through an arbiter.
//====================================================================

`timescale 1ns/1ps

module uart_subsys (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            start_i,
	output logic                            cfg_done_o,
	input  logic                            tx_valid_i,
	input  logic [uart_pkg::WB_DATA_W-1:0] tx_data_i,
	output logic                            tx_ready_o,
	output logic                            txd_o,
	output logic                            irq_o
);
	import uart_pkg::*;

	logic                 m0_cyc, m0_stb, m0_we, m0_ack;
	logic [WB_ADDR_W-1:0] m0_adr;
	logic [WB_DATA_W-1:0] m0_dat_w, m0_dat_r;
	logic                 m1_cyc, m1_stb, m1_we, m1_ack;
	logic [WB_ADDR_W-1:0] m1_adr;
	logic [WB_DATA_W-1:0] m1_dat_w, m1_dat_r;
	logic                 s_cyc, s_stb, s_we, s_ack;
	logic [WB_ADDR_W-1:0] s_adr;
	logic [WB_DATA_W-1:0] s_dat_w, s_dat_r;
	logic                 tx_start, tx_busy;
	logic [WB_DATA_W-1:0] tx_byte;
	logic [DIV_W-1:0]     divisor;

	uart_cfg_master i_uart_cfg_master (
		.clk        (clk),
		.rstn       (rstn),
		.start_i    (start_i),
		.cfg_done_o (cfg_done_o),
		.wb_cyc_o   (m0_cyc),
		.wb_stb_o   (m0_stb),
		.wb_we_o    (m0_we),
		.wb_adr_o   (m0_adr),
		.wb_dat_o   (m0_dat_w),
		.wb_dat_i   (m0_dat_r),
		.wb_ack_i   (m0_ack)
	);

	uart_tx_feeder i_uart_tx_feeder (
		.clk        (clk),
		.rstn       (rstn),
		.enable_i   (cfg_done_o), // Feed only after configuration.
		.tx_valid_i (tx_valid_i),
		.tx_data_i  (tx_data_i),
		.tx_ready_o (tx_ready_o),
		.wb_cyc_o   (m1_cyc),
		.wb_stb_o   (m1_stb),
		.wb_we_o    (m1_we),
		.wb_adr_o   (m1_adr),
		.wb_dat_o   (m1_dat_w),
		.wb_dat_i   (m1_dat_r),
		.wb_ack_i   (m1_ack)
	);

	wb_arbiter i_wb_arbiter (
		.clk      (clk),
		.rstn     (rstn),
		.m0_cyc_i (m0_cyc),
		.m0_stb_i (m0_stb),
		.m0_we_i  (m0_we),
		.m0_adr_i (m0_adr),
		.m0_dat_i (m0_dat_w),
		.m0_ack_o (m0_ack),
		.m0_dat_o (m0_dat_r),
		.m1_cyc_i (m1_cyc),
		.m1_stb_i (m1_stb),
		.m1_we_i  (m1_we),
		.m1_adr_i (m1_adr),
		.m1_dat_i (m1_dat_w),
		.m1_ack_o (m1_ack),
		.m1_dat_o (m1_dat_r),
		.s_cyc_o  (s_cyc),
		.s_stb_o  (s_stb),
		.s_we_o   (s_we),
		.s_adr_o  (s_adr),
		.s_dat_o  (s_dat_w),
		.s_dat_i  (s_dat_r),
		.s_ack_i  (s_ack)
	);

	uart_regs i_uart_regs (
		.clk        (clk),
		.rstn       (rstn),
		.wb_cyc_i   (s_cyc),
		.wb_stb_i   (s_stb),
		.wb_we_i    (s_we),
		.wb_adr_i   (s_adr),
		.wb_dat_i   (s_dat_w),
		.wb_dat_o   (s_dat_r),
		.wb_ack_o   (s_ack),
		.tx_start_o (tx_start),
		.tx_byte_o  (tx_byte),
		.divisor_o  (divisor),
		.tx_busy_i  (tx_busy),
		.irq_o      (irq_o)
	);

	uart_tx_core i_uart_tx_core (
		.clk       (clk),
		.rstn      (rstn),
		.start_i   (tx_start),
		.byte_i    (tx_byte),
		.divisor_i (divisor),
		.txd_o     (txd_o),
		.busy_o    (tx_busy)
	);

endmodule

/* tb_uart_subsys.sv */
//====================================================================
// UART subsystem testbench
// Configures the UART, feeds a byte table and decodes txd frames.
//====================================================================

`timescale 1ns/1ps

module tb_uart_subsys;
	import uart_pkg::*;

	localparam int          N_BYTES        = 8;
	localparam int          DIV            = int'(CFG_DIVISOR);
	localparam int          TIMEOUT_CYCLES = 200 + N_BYTES * 14 * DIV;
	localparam logic [31:0] SEED           = 32'h2b81dddd;

	logic                 clk;
	logic                 rstn;
	logic                 start_i;
	logic                 cfg_done_o;
	logic                 tx_valid_i;
	logic [WB_DATA_W-1:0] tx_data_i;
	logic                 tx_ready_o;
	logic                 txd_o;
	logic                 irq_o;

	logic [WB_DATA_W-1:0] tx_table[$]; // Bytes to send, also the expected line data.
	int                   n_sent;
	int                   n_rcvd;
	int                   cycle_cnt = 0;

	uart_subsys i_uart_subsys (
		.clk        (clk),
		.rstn       (rstn),
		.start_i    (start_i),
		.cfg_done_o (cfg_done_o),
		.tx_valid_i (tx_valid_i),
		.tx_data_i  (tx_data_i),
		.tx_ready_o (tx_ready_o),
		.txd_o      (txd_o),
		.irq_o      (irq_o)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		assert (cycle_cnt < TIMEOUT_CYCLES)
			else abort_run("Timeout: the run did not finish within the cycle limit");
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp)
			else abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
			else abort_run($sformatf("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp));
	endtask

	task automatic send_bytes();
		for (int i = 0; i < N_BYTES; i++) begin
			tx_valid_i = 1'b1;
			tx_data_i  = tx_table[i];
			while (!tx_ready_o) begin
				@(posedge clk);
				#1;
			end
			@(posedge clk); // Byte taken on this edge.
			#1;
			n_sent++;
			assert (n_sent - n_rcvd <= 2)
				else abort_run("Feeder took a byte while two were still in flight");
		end
		tx_valid_i = 1'b0;
	endtask

	task automatic receive_frame(input logic [7:0] exp_byte);
		logic [7:0] rx_byte;
		logic       bit_val;
		int         bit_idx;
		rx_byte = '0;
		bit_val = 1'b0;
		do begin
			@(negedge clk);
			check_bit("cfg_done_o", cfg_done_o, 1'b1);
		end while (txd_o);
		// The line may only change on bit boundaries, so bit lengths are exact.
		for (int j = 0; j < 10 * DIV; j++) begin
			if (j > 0)
				@(negedge clk);
			bit_idx = j / DIV;
			if (j % DIV == 0)
				bit_val = txd_o; // First cycle of a bit.
			else
				check_bit("txd_o", txd_o, bit_val);
			check_bit("irq_o", irq_o, 1'b0);
			if (j % DIV == DIV / 2 && bit_idx >= 1 && bit_idx <= 8)
				rx_byte = {txd_o, rx_byte[7:1]}; // Mid-bit sample.
			if (j % DIV == DIV / 2 && bit_idx == 9)
				check_bit("txd_o", txd_o, 1'b1); // Stop bit.
		end
		check_byte("rx_byte", rx_byte, exp_byte);
	endtask

	task automatic receive_bytes();
		for (int i = 0; i < N_BYTES; i++) begin
			receive_frame(tx_table[i]);
			n_rcvd++;
		end
	endtask

	initial begin
		logic [31:0] rnd;
		clk        = 1'b0;
		rstn       = 1'b0;
		start_i    = 1'b0;
		tx_valid_i = 1'b0;
		tx_data_i  = '0;
		n_sent     = 0;
		n_rcvd     = 0;
		rnd        = $urandom(SEED);

		tx_table.push_back(8'h00);
		tx_table.push_back(8'hff);
		tx_table.push_back(8'h55);
		tx_table.push_back(8'ha3);
		while (tx_table.size() < N_BYTES) begin
			rnd = $urandom;
			tx_table.push_back(rnd[7:0]);
		end

		repeat (10) @(posedge clk);
		#1;
		rstn = 1'b1;

		// Feeder is not enabled yet, so the offered byte must be ignored.
		tx_valid_i = 1'b1;
		tx_data_i  = 8'h5a;
		repeat (20) begin
			@(negedge clk);
			check_bit("txd_o", txd_o, 1'b1);
			check_bit("cfg_done_o", cfg_done_o, 1'b0);
			check_bit("tx_ready_o", tx_ready_o, 1'b0);
			check_bit("irq_o", irq_o, 1'b0);
		end

		@(posedge clk);
		#1;
		tx_valid_i = 1'b0;
		start_i    = 1'b1;
		@(posedge clk);
		#1;
		start_i = 1'b0;

		while (!cfg_done_o)
			@(negedge clk);
		@(negedge clk);
		check_bit("cfg_done_o", cfg_done_o, 1'b1);
		check_bit("irq_o", irq_o, 1'b1); // ETBEI set, nothing pending.

		@(posedge clk);
		#1;
		fork
			send_bytes();
			receive_bytes();
		join

		// Line idle and interrupt back after the last stop bit.
		repeat (2 * DIV) begin
			@(negedge clk);
			check_bit("txd_o", txd_o, 1'b1);
			check_bit("irq_o", irq_o, 1'b1);
			check_bit("tx_ready_o", tx_ready_o, 1'b1);
			check_bit("cfg_done_o", cfg_done_o, 1'b1);
		end

		$display("** PASS **");
		$finish;
	end

endmodule

/* uart_subsys.f */
uart_pkg.sv
uart_tx_core.sv
uart_regs.sv
wb_arbiter.sv
uart_tx_feeder.sv
uart_cfg_master.sv
uart_subsys.sv
tb_uart_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UART subsystem testbench with Verilator.
set -e

verilator --binary --timing --assert -j 0 \
	--top-module tb_uart_subsys -f uart_subsys.f

./obj_dir/Vtb_uart_subsys | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation finished without errors"
